// File: files.f
hdl/video_pkg.sv
hdl/video_ram.sv
hdl/video_timing.sv
hdl/bus_decoder.sv
hdl/tile_layer.sv
hdl/color_output.sv
hdl/video_top.sv
dv/video_asserts.sv
dv/tb_video_top.sv

// File: dv/tb_video_top.sv
`timescale 1ns/1ps

module tb_video_top;

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DLY = 1;
	// ack comes one clock after the request
	localparam int ACK_LATENCY = 1;
	localparam int ACK_LIMIT = 8;
	localparam int FRAME_STROBES = video_pkg::H_TOTAL * video_pkg::V_TOTAL;
	// 12 frames of system clocks
	localparam int WATCHDOG_CLKS = 12 * FRAME_STROBES * video_pkg::PIX_DIV;

	logic               clk;
	logic               arst_n;
	video_pkg::wb_req_t wb_req;
	video_pkg::wb_rsp_t wb_rsp;
	logic               vid_ce;
	video_pkg::rgb_t    vid_rgb;
	logic               vid_hsync_n;
	logic               vid_vsync_n;
	logic               vid_hblank_n;
	logic               vid_vblank_n;
	logic               vid_csync_n;

	// shadow copies of both RAMs
	video_pkg::dot_t map_mem [video_pkg::MAP_DEPTH];
	video_pkg::rgb_t pal_mem [video_pkg::PAL_DEPTH];
	logic [31:0] lcg_state = 32'ha220_cb56;

	video_top u_dut (
		.clk         (clk),
		.arst_n      (arst_n),
		.wb_req      (wb_req),
		.wb_rsp      (wb_rsp),
		.vid_ce      (vid_ce),
		.vid_rgb     (vid_rgb),
		.vid_hsync_n (vid_hsync_n),
		.vid_vsync_n (vid_vsync_n),
		.vid_hblank_n(vid_hblank_n),
		.vid_vblank_n(vid_vblank_n),
		.vid_csync_n (vid_csync_n)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////////////////////////
	// failure reporting and compares
	////////////////////////////////////////

	task automatic fail_run(input string line);
		$display("%s", line);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic check_rgb(input string what, input video_pkg::rgb_t got,
		input video_pkg::rgb_t exp);
		if (got !== exp) begin
			fail_run($sformatf("[ERROR] %0t: %s color %03h, expected %03h", $time, what, got, exp));
		end
	endtask

	task automatic check_data(input string what, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("[ERROR] %0t: %s data %04h, expected %04h", $time, what, got, exp));
		end
	endtask

	task automatic check_count(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp));
		end
	endtask

	// error count from both bound checkers
	function automatic int assert_failures();
		return u_dut.u_bus.u_bus_chk.fail_cnt + u_dut.u_color.u_color_chk.fail_cnt;
	endfunction

	always @(negedge clk) begin
		if (assert_failures() != 0) begin
			fail_run("a bound assertion on the DUT failed");
		end
	end

	initial begin
		#(WATCHDOG_CLKS * CLK_PERIOD);
		fail_run("watchdog expired, the run timed out before the tests finished");
	end

	////////////////////////////////////////
	// Wishbone host
	////////////////////////////////////////

	// one classic cycle with ack sampled mid clock
	task automatic wb_access(input logic we, input logic [9:0] adr, input logic [15:0] wdat,
		output logic [15:0] rdat);
		int clocks;
		@(posedge clk);
		#DRIVE_DLY;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we = we;
		wb_req.adr = adr;
		wb_req.dat = wdat;
		clocks = 0;
		do begin
			@(posedge clk);
			clocks++;
			@(negedge clk);
			if (clocks > ACK_LIMIT) begin
				fail_run("no Wishbone ack arrived for the request");
			end
		end while (!wb_rsp.ack);
		check_count("ack latency", clocks, ACK_LATENCY);
		rdat = wb_rsp.dat;
		// the edge closing the ack cycle ends the transfer
		@(posedge clk);
		#DRIVE_DLY;
		wb_req = '0;
		@(negedge clk);
		check_count("ack after access", wb_rsp.ack, 0);
	endtask

	task automatic wb_write(input logic [9:0] adr, input logic [15:0] wdat);
		logic [15:0] unused;
		wb_access(1'b1, adr, wdat, unused);
	endtask

	task automatic wb_read(input logic [9:0] adr, output logic [15:0] rdat);
		wb_access(1'b0, adr, 16'h0000, rdat);
	endtask

	task automatic write_tile(input int idx, input video_pkg::dot_t d);
		wb_write(video_pkg::ADR_TILE_BASE + 10'(idx), 16'(d));
		map_mem[idx] = d;
	endtask

	task automatic write_palette(input int idx, input video_pkg::rgb_t c);
		wb_write(video_pkg::ADR_PAL_BASE + 10'(idx), 16'(c));
		pal_mem[idx] = c;
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	////////////////////////////////////////
	// raster observation
	////////////////////////////////////////

	// each pixel sampled once mid clock while vid_ce is high
	task automatic next_pixel();
		do begin
			@(negedge clk);
		end while (!vid_ce);
	endtask

	// skip to pixel 0,0 of the next frame
	task automatic wait_frame_start();
		next_pixel();
		while (!vid_vblank_n) next_pixel();
		while (vid_vblank_n) next_pixel();
		while (!vid_vblank_n) next_pixel();
	endtask

	// palette entry of the map cell under the scrolled beam
	function automatic video_pkg::rgb_t expected_rgb(input int x, input int y, input int scroll);
		int col;
		int row;
		if (x >= video_pkg::H_ACTIVE || y >= video_pkg::V_ACTIVE) begin
			return '0;
		end
		col = ((x + scroll) / video_pkg::TILE_SIZE) % video_pkg::MAP_COLS;
		row = (y / video_pkg::TILE_SIZE) % video_pkg::MAP_ROWS;
		return pal_mem[map_mem[row * video_pkg::MAP_COLS + col]];
	endfunction

	task automatic check_frame(input int scroll);
		int i;
		int x;
		int y;
		wait_frame_start();
		for (i = 0; i < FRAME_STROBES; i++) begin
			if (i > 0) begin
				next_pixel();
			end
			x = i % video_pkg::H_TOTAL;
			y = i / video_pkg::H_TOTAL;
			check_rgb($sformatf("pixel %0d,%0d", x, y), vid_rgb, expected_rgb(x, y, scroll));
		end
	endtask

	////////////////////////////////////////
	// directed tests
	////////////////////////////////////////

	task automatic test_reset_state();
		logic [15:0] rdat;
		arst_n = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_rgb("reset", vid_rgb, 12'h000);
		check_count("reset ack", wb_rsp.ack, 0);
		check_count("reset hblank_n", vid_hblank_n, 0);
		check_count("reset vblank_n", vid_vblank_n, 0);
		@(posedge clk);
		#DRIVE_DLY;
		arst_n = 1'b1;
		wb_read(video_pkg::ADR_SCROLL, rdat);
		check_data("scroll after reset", rdat, 16'h0000);
	endtask

	task automatic test_scroll_access();
		logic [15:0] rdat;
		// only the low 7 bits are kept
		wb_write(video_pkg::ADR_SCROLL, 16'hffb5);
		wb_read(video_pkg::ADR_SCROLL, rdat);
		check_data("scroll readback", rdat, 16'h0035);
		// other addresses read as zero
		wb_read(video_pkg::ADR_PAL_BASE + 10'd3, rdat);
		check_data("palette readback", rdat, 16'h0000);
		wb_write(video_pkg::ADR_SCROLL, 16'h0000);
	endtask

	task automatic test_raster();
		int strobes;
		int act;
		int hs;
		int lines;
		int vis_lines;
		int vs_lines;
		int clocks;
		int k;
		logic prev_hb;
		logic vis;
		logic vs;
		wait_frame_start();
		lines = 0;
		vis_lines = 0;
		vs_lines = 0;
		// one line per pass split at rising hblank_n
		do begin
			strobes = 0;
			act = 0;
			hs = 0;
			vis = vid_vblank_n;
			vs = !vid_vsync_n;
			do begin
				strobes++;
				act += vid_hblank_n;
				hs += !vid_hsync_n;
				check_count("csync_n", vid_csync_n, vid_hsync_n & vid_vsync_n);
				prev_hb = vid_hblank_n;
				next_pixel();
			end while (!(vid_hblank_n && !prev_hb));
			check_count("strobes per line", strobes, video_pkg::H_TOTAL);
			check_count("unblanked pixels per line", act, video_pkg::H_ACTIVE);
			check_count("hsync strobes per line", hs, video_pkg::H_SYNC);
			lines++;
			vis_lines += vis;
			vs_lines += vs;
		end while (!(vid_vblank_n && !vis));
		check_count("lines per frame", lines, video_pkg::V_TOTAL);
		check_count("unblanked lines", vis_lines, video_pkg::V_ACTIVE);
		check_count("vsync lines", vs_lines, video_pkg::V_SYNC);
		// vid_ce high once every PIX_DIV clocks
		for (k = 0; k < 4; k++) begin
			clocks = 0;
			do begin
				@(negedge clk);
				clocks++;
			end while (!vid_ce);
			check_count("clocks per strobe", clocks, video_pkg::PIX_DIV);
		end
	endtask

	task automatic test_flat_fill();
		int idx;
		for (idx = 0; idx < video_pkg::MAP_DEPTH; idx++) begin
			write_tile(idx, 8'h5a);
		end
		write_palette(8'h5a, 12'h9c3);
		check_frame(0);
	endtask

	task automatic test_random_scroll();
		int idx;
		logic [31:0] r;
		int scrolls [3] = '{5, 64, 123};
		for (idx = 0; idx < video_pkg::MAP_DEPTH; idx++) begin
			r = lcg_next();
			write_tile(idx, r[23:16]);
		end
		for (idx = 0; idx < video_pkg::PAL_DEPTH; idx++) begin
			r = lcg_next();
			write_palette(idx, r[27:16]);
		end
		foreach (scrolls[k]) begin
			wb_write(video_pkg::ADR_SCROLL, 16'(scrolls[k]));
			check_frame(scrolls[k]);
		end
	endtask

	initial begin
		$timeformat(-9, 0, " ns", 0);
		arst_n = 1'b0;
		wb_req = '0;
		test_reset_state();
		test_scroll_access();
		test_raster();
		test_flat_fill();
		test_random_scroll();
		if (assert_failures() != 0) begin
			fail_run("bound assertions flagged the DUT");
		end else begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule

// File: dv/video_asserts.sv
`timescale 1ns/1ps

module video_asserts (
	input logic            clk,
	input logic            arst_n,
	input logic            req,
	input logic            ack,
	input logic            pix_ce,
	input logic            vis_in,
	input video_pkg::rgb_t rgb
);

	// count of failed properties
	int fail_cnt = 0;

	////////////////////////////////////////
	// Wishbone handshake
	////////////////////////////////////////

	// ack lasts one clock only
	ack_single: assert property (@(posedge clk) disable iff (!arst_n) ack |=> !ack)
		else begin
			fail_cnt++;
			$error("ack held high for two clocks");
		end

	// no ack outside a request
	ack_in_req: assert property (@(posedge clk) disable iff (!arst_n) ack |-> req)
		else begin
			fail_cnt++;
			$error("ack without cyc and stb");
		end

	// new request answered on the next clock
	ack_latency: assert property (@(posedge clk) disable iff (!arst_n) $rose(req) |=> ack)
		else begin
			fail_cnt++;
			$error("ack missing one clock after request");
		end

	////////////////////////////////////////
	// video outputs
	////////////////////////////////////////

	// blank at the stage input gives black after the strobe
	blank_black: assert property (@(posedge clk) disable iff (!arst_n)
		pix_ce && !vis_in |=> rgb == '0)
		else begin
			fail_cnt++;
			$error("color not black during blanking");
		end

endmodule

// handshake checks on the bus slave
bind bus_decoder video_asserts u_bus_chk (
	.clk   (clk),
	.arst_n(arst_n),
	.req   (wb_req.cyc & wb_req.stb),
	.ack   (wb_rsp.ack),
	.pix_ce(1'b0),
	.vis_in(1'b1),
	.rgb   ('0)
);

// blanking check on the color stage
bind color_output video_asserts u_color_chk (
	.clk   (clk),
	.arst_n(arst_n),
	.req   (1'b0),
	.ack   (1'b0),
	.pix_ce(pix_ce),
	.vis_in(beam_in.hblank_n & beam_in.vblank_n),
	.rgb   (rgb)
);

// File: hdl/video_top.sv
`timescale 1ns/1ps

module video_top (
	input  logic               clk,
	input  logic               arst_n,
	input  video_pkg::wb_req_t wb_req,
	output video_pkg::wb_rsp_t wb_rsp,
	output logic               vid_ce,
	output video_pkg::rgb_t    vid_rgb,
	output logic               vid_hsync_n,
	output logic               vid_vsync_n,
	output logic               vid_hblank_n,
	output logic               vid_vblank_n,
	output logic               vid_csync_n
);

	logic pix_ce;
	// beam at each pipeline stage
	video_pkg::beam_t timing_beam;
	video_pkg::beam_t tile_beam;
	video_pkg::beam_t out_beam;
	video_pkg::dot_t dot;
	// host writes into the two RAMs
	video_pkg::ram_wr_t tile_wr;
	video_pkg::ram_wr_t pal_wr;
	logic [video_pkg::SCROLL_W-1:0] scroll_x;

	////////////////////////////////////////
	// timing and host bus
	////////////////////////////////////////

	video_timing u_timing (
		.clk   (clk),
		.arst_n(arst_n),
		.pix_ce(pix_ce),
		.beam  (timing_beam)
	);

	bus_decoder u_bus (
		.clk     (clk),
		.arst_n  (arst_n),
		.wb_req  (wb_req),
		.wb_rsp  (wb_rsp),
		.tile_wr (tile_wr),
		.pal_wr  (pal_wr),
		.scroll_x(scroll_x)
	);

	////////////////////////////////////////
	// pixel pipeline, two strobes deep
	////////////////////////////////////////

	tile_layer u_tile (
		.clk     (clk),
		.arst_n  (arst_n),
		.pix_ce  (pix_ce),
		.beam_in (timing_beam),
		.scroll_x(scroll_x),
		.tile_wr (tile_wr),
		.dot     (dot),
		.beam_out(tile_beam)
	);

	color_output u_color (
		.clk     (clk),
		.arst_n  (arst_n),
		.pix_ce  (pix_ce),
		.dot     (dot),
		.beam_in (tile_beam),
		.pal_wr  (pal_wr),
		.rgb     (vid_rgb),
		.beam_out(out_beam),
		.csync_n (vid_csync_n)
	);

	// sample strobe for an observer
	assign vid_ce = pix_ce;
	// sync and blank leave with the color
	assign vid_hsync_n = out_beam.hsync_n;
	assign vid_vsync_n = out_beam.vsync_n;
	assign vid_hblank_n = out_beam.hblank_n;
	assign vid_vblank_n = out_beam.vblank_n;

endmodule

// File: hdl/color_output.sv
`timescale 1ns/1ps

module color_output (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               pix_ce,
	input  video_pkg::dot_t    dot,
	input  video_pkg::beam_t   beam_in,
	input  video_pkg::ram_wr_t pal_wr,
	output video_pkg::rgb_t    rgb,
	output video_pkg::beam_t   beam_out,
	output logic               csync_n
);

	////////////////////////////////////////
	// palette lookup
	////////////////////////////////////////

	// raw palette color, before blanking
	video_pkg::rgb_t pal_rgb;
	logic visible;

	// dot index is the palette address
	video_ram #(
		.payload_t(video_pkg::rgb_t),
		.DEPTH    (video_pkg::PAL_DEPTH)
	) u_pal_ram (
		.clk    (clk),
		.wr     (pal_wr),
		.rd_en  (pix_ce),
		.rd_adr (dot),
		.rd_data(pal_rgb)
	);

	////////////////////////////////////////
	// beam delay and blanking
	////////////////////////////////////////

	// second pipeline stage of the beam
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			beam_out <= video_pkg::BEAM_IDLE;
		end else if (pix_ce) begin
			beam_out <= beam_in;
		end
	end

	// both blanks inactive
	assign visible = beam_out.hblank_n & beam_out.vblank_n;

	// black outside active area
	// blanks are low from reset, so the color starts black
	assign rgb = visible ? pal_rgb : video_pkg::RGB_BLACK;

	// composite sync, low when either sync is low
	assign csync_n = beam_out.hsync_n & beam_out.vsync_n;

endmodule

// File: hdl/tile_layer.sv
`timescale 1ns/1ps

module tile_layer (
	input  logic                           clk,
	input  logic                           arst_n,
	input  logic                           pix_ce,
	input  video_pkg::beam_t               beam_in,
	input  logic [video_pkg::SCROLL_W-1:0] scroll_x,
	input  video_pkg::ram_wr_t             tile_wr,
	output video_pkg::dot_t                dot,
	output video_pkg::beam_t               beam_out
);

	////////////////////////////////////////
	// map cell lookup
	////////////////////////////////////////

	// scrolled x, wraps at map width
	logic [video_pkg::HCNT_W-1:0] x_pos;
	logic [video_pkg::MAP_COL_W-1:0] map_col;
	logic [video_pkg::MAP_ROW_W-1:0] map_row;
	logic [video_pkg::RAM_ADR_W-1:0] map_adr;

	assign x_pos = beam_in.hcnt + scroll_x;

	// divide by tile size, modulo map size
	assign map_col = x_pos[video_pkg::TILE_SHIFT +: video_pkg::MAP_COL_W];
	// rows are not scrolled
	assign map_row = beam_in.vcnt[video_pkg::TILE_SHIFT +: video_pkg::MAP_ROW_W];

	// row major, MAP_COLS entries per row
	always_comb begin
		map_adr = '0;
		map_adr[video_pkg::MAP_ROW_W + video_pkg::MAP_COL_W - 1:0] = {map_row, map_col};
	end

	// map entry read on the strobe, out one pixel later
	video_ram #(
		.payload_t(video_pkg::dot_t),
		.DEPTH    (video_pkg::MAP_DEPTH)
	) u_map_ram (
		.clk    (clk),
		.wr     (tile_wr),
		.rd_en  (pix_ce),
		.rd_adr (map_adr),
		.rd_data(dot)
	);

	////////////////////////////////////////
	// beam delay
	////////////////////////////////////////

	// one strobe, lines up with the RAM read
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			beam_out <= video_pkg::BEAM_IDLE;
		end else if (pix_ce) begin
			beam_out <= beam_in;
		end
	end

endmodule

// File: hdl/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder (
	input  logic                           clk,
	input  logic                           arst_n,
	input  video_pkg::wb_req_t             wb_req,
	output video_pkg::wb_rsp_t             wb_rsp,
	output video_pkg::ram_wr_t             tile_wr,
	output video_pkg::ram_wr_t             pal_wr,
	output logic [video_pkg::SCROLL_W-1:0] scroll_x
);

	logic req;
	logic ack;
	logic wr_fire;
	logic [video_pkg::WB_ADR_W-1:0] page;
	logic sel_tile;
	logic sel_pal;
	logic sel_scroll;
	logic [video_pkg::WB_DAT_W-1:0] rd_dat;

	////////////////////////////////////////
	// handshake
	////////////////////////////////////////

	assign req = wb_req.cyc & wb_req.stb;

	// ack one clock after request, never two in a row
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ack <= 1'b0;
		end else begin
			ack <= req & ~ack;
		end
	end

	// write lands on the edge closing the ack cycle
	assign wr_fire = ack & req & wb_req.we;

	////////////////////////////////////////
	// address decode
	////////////////////////////////////////

	// 256 word pages
	assign page = wb_req.adr >> video_pkg::RAM_ADR_W;
	assign sel_tile = (page == (video_pkg::ADR_TILE_BASE >> video_pkg::RAM_ADR_W));
	assign sel_pal = (page == (video_pkg::ADR_PAL_BASE >> video_pkg::RAM_ADR_W));
	// scroll is a single word
	assign sel_scroll = (wb_req.adr == video_pkg::ADR_SCROLL);

	// both RAMs see the same address and data
	assign tile_wr.we = wr_fire & sel_tile;
	assign tile_wr.adr = wb_req.adr[video_pkg::RAM_ADR_W-1:0];
	assign tile_wr.dat = wb_req.dat[video_pkg::RAM_DAT_W-1:0];
	assign pal_wr.we = wr_fire & sel_pal;
	assign pal_wr.adr = wb_req.adr[video_pkg::RAM_ADR_W-1:0];
	assign pal_wr.dat = wb_req.dat[video_pkg::RAM_DAT_W-1:0];

	// scroll register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			scroll_x <= '0;
		end else if (wr_fire && sel_scroll) begin
			scroll_x <= wb_req.dat[video_pkg::SCROLL_W-1:0];
		end
	end

	// readback, zero everywhere but scroll
	always_comb begin
		rd_dat = '0;
		if (sel_scroll) begin
			rd_dat[video_pkg::SCROLL_W-1:0] = scroll_x;
		end
	end

	assign wb_rsp.ack = ack;
	assign wb_rsp.dat = rd_dat;

endmodule

// File: hdl/video_timing.sv
`timescale 1ns/1ps

module video_timing (
	input  logic             clk,
	input  logic             arst_n,
	output logic             pix_ce,
	output video_pkg::beam_t beam
);

	////////////////////////////////////////
	// pixel strobe
	////////////////////////////////////////

	logic [video_pkg::PIX_DIV_W-1:0] div_cnt;

	// free running divider
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			div_cnt <= '0;
		end else if (pix_ce) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// one clock in PIX_DIV
	assign pix_ce = (int'(div_cnt) == video_pkg::PIX_DIV - 1);

	////////////////////////////////////////
	// beam counters
	////////////////////////////////////////

	logic [video_pkg::HCNT_W-1:0] h_nxt;
	logic [video_pkg::VCNT_W-1:0] v_nxt;

	// next position, line wrap then frame wrap
	always_comb begin
		h_nxt = beam.hcnt + 1'b1;
		v_nxt = beam.vcnt;
		if (int'(beam.hcnt) == video_pkg::H_TOTAL - 1) begin
			h_nxt = '0;
			if (int'(beam.vcnt) == video_pkg::V_TOTAL - 1) begin
				v_nxt = '0;
			end else begin
				v_nxt = beam.vcnt + 1'b1;
			end
		end
	end

	// counts and decoded sync/blank registered together,
	// so the beam word is always self consistent
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			beam <= video_pkg::BEAM_IDLE;
		end else if (pix_ce) begin
			beam.hcnt <= h_nxt;
			beam.vcnt <= v_nxt;
			// blank low outside active area
			beam.hblank_n <= (int'(h_nxt) < video_pkg::H_ACTIVE);
			beam.vblank_n <= (int'(v_nxt) < video_pkg::V_ACTIVE);
			// sync pulse after front porch
			beam.hsync_n <= !((int'(h_nxt) >= video_pkg::H_ACTIVE + video_pkg::H_FRONT) &&
				(int'(h_nxt) < video_pkg::H_ACTIVE + video_pkg::H_FRONT + video_pkg::H_SYNC));
			beam.vsync_n <= !((int'(v_nxt) >= video_pkg::V_ACTIVE + video_pkg::V_FRONT) &&
				(int'(v_nxt) < video_pkg::V_ACTIVE + video_pkg::V_FRONT + video_pkg::V_SYNC));
		end
	end

endmodule

// File: hdl/video_ram.sv
`timescale 1ns/1ps

module video_ram #(
	parameter type payload_t = video_pkg::dot_t,
	parameter int  DEPTH     = 256
) (
	input  logic                            clk,
	input  video_pkg::ram_wr_t              wr,
	input  logic                            rd_en,
	input  logic [video_pkg::RAM_ADR_W-1:0] rd_adr,
	output payload_t                        rd_data
);

	// storage, no reset on contents
	payload_t mem [DEPTH];

	// index bits actually decoded
	logic [$clog2(DEPTH)-1:0] wr_idx;
	logic [$clog2(DEPTH)-1:0] rd_idx;
	// low data bits that the payload needs
	logic [$bits(payload_t)-1:0] wr_bits;

	assign wr_idx = wr.adr[$clog2(DEPTH)-1:0];
	assign rd_idx = rd_adr[$clog2(DEPTH)-1:0];
	assign wr_bits = wr.dat[$bits(payload_t)-1:0];

	// single write port
	always_ff @(posedge clk) begin
		if (wr.we) begin
			mem[wr_idx] <= payload_t'(wr_bits);
		end
	end

	// registered read, holds while rd_en low
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_idx];
		end
	end

endmodule

// File: hdl/video_pkg.sv
package video_pkg;

	////////////////////////////////////////
	// raster geometry
	////////////////////////////////////////

	// system clocks per pixel strobe
	localparam int PIX_DIV = 2;
	localparam int PIX_DIV_W = $clog2(PIX_DIV);

	// horizontal, in pixels
	// sync starts at H_ACTIVE + H_FRONT
	localparam int H_ACTIVE = 64;
	localparam int H_FRONT = 4;
	localparam int H_SYNC = 6;
	localparam int H_TOTAL = 80;

	// vertical, in lines, same convention
	localparam int V_ACTIVE = 32;
	localparam int V_FRONT = 2;
	localparam int V_SYNC = 2;
	localparam int V_TOTAL = 40;

	// beam counter widths
	localparam int HCNT_W = $clog2(H_TOTAL);
	localparam int VCNT_W = $clog2(V_TOTAL);

	// tile map, wraps both ways
	localparam int TILE_SIZE = 8;
	localparam int TILE_SHIFT = $clog2(TILE_SIZE);
	localparam int MAP_COLS = 16;
	localparam int MAP_ROWS = 8;
	localparam int MAP_COL_W = $clog2(MAP_COLS);
	localparam int MAP_ROW_W = $clog2(MAP_ROWS);
	localparam int MAP_DEPTH = MAP_COLS * MAP_ROWS;

	// one palette entry per dot index
	localparam int PAL_DEPTH = 256;

	////////////////////////////////////////
	// host bus address map
	////////////////////////////////////////

	localparam int WB_ADR_W = 10;
	localparam int WB_DAT_W = 16;
	localparam int RAM_ADR_W = 8;
	localparam int RAM_DAT_W = 12;
	// scroll covers one full map width
	localparam int SCROLL_W = HCNT_W;

	// word addresses, each region one 256 word page
	localparam logic [WB_ADR_W-1:0] ADR_TILE_BASE = 10'h000;
	localparam logic [WB_ADR_W-1:0] ADR_PAL_BASE = 10'h100;
	localparam logic [WB_ADR_W-1:0] ADR_SCROLL = 10'h200;

	////////////////////////////////////////
	// shared types
	////////////////////////////////////////

	// timing word, travels alongside pixel data
	typedef struct packed {
		logic [HCNT_W-1:0] hcnt;
		logic [VCNT_W-1:0] vcnt;
		logic              hsync_n;
		logic              vsync_n;
		logic              hblank_n;
		logic              vblank_n;
	} beam_t;

	// 8 bit color index
	typedef logic [7:0] dot_t;

	// 4:4:4 color
	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb_t;

	// write request from decoder to one RAM
	typedef struct packed {
		logic                 we;
		logic [RAM_ADR_W-1:0] adr;
		logic [RAM_DAT_W-1:0] dat;
	} ram_wr_t;

	// Wishbone host side
	typedef struct packed {
		logic                cyc;
		logic                stb;
		logic                we;
		logic [WB_ADR_W-1:0] adr;
		logic [WB_DAT_W-1:0] dat;
	} wb_req_t;

	// Wishbone slave side
	typedef struct packed {
		logic                ack;
		logic [WB_DAT_W-1:0] dat;
	} wb_rsp_t;

	// reset beam: counts zero, syncs idle, blanking active
	localparam beam_t BEAM_IDLE = '{
		hcnt:     '0,
		vcnt:     '0,
		hsync_n:  1'b1,
		vsync_n:  1'b1,
		hblank_n: 1'b0,
		vblank_n: 1'b0
	};

	localparam rgb_t RGB_BLACK = '0;

endpackage
